/* src.f */
hdl/rv32i_types.sv
hdl/ctrl_types.sv
hdl/control_unit.sv
hdl/regfile.sv
hdl/alu.sv
hdl/cmp.sv
hdl/datapath.sv
tb/datapath_checks.sv
tb/datapath_tb.sv

/* Bender.yml */
package:
  name: rv32i_pipe

sources:
  - hdl/rv32i_types.sv
  - hdl/ctrl_types.sv
  - hdl/control_unit.sv
  - hdl/regfile.sv
  - hdl/alu.sv
  - hdl/cmp.sv
  - hdl/datapath.sv
  - target: test
    files:
      - tb/datapath_checks.sv
      - tb/datapath_tb.sv

/* tb/datapath_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module datapath_tb;
    import rv32i_types::*;

    localparam rv32i_word start_pc   = 32'h0000_1000;
    localparam int        n_inst     = 400;
    localparam int        max_cycles = 4000;

    typedef struct packed {
        rv32i_reg_idx rd;
        rv32i_word    data;
    } retire_rec_t;

    logic         clk = 1'b0;
    logic         reset;
    rv32i_word    inst_rdata;
    logic         inst_resp;
    rv32i_word    inst_addr;
    logic         inst_read;
    logic         retire_valid;
    rv32i_reg_idx retire_rd;
    rv32i_word    retire_data;
    logic         will_retire;
    logic         check_failed;
    integer       seed;
    rv32i_word    model [32];  // reference register state
    retire_rec_t  exp_q [$];
    retire_rec_t  exp_head;
    logic         exp_ready;

    always #5 clk = ~clk;

    datapath #(.reset_pc(start_pc)) i_dut (
        .clk          (clk),
        .reset        (reset),
        .inst_rdata   (inst_rdata),
        .inst_resp    (inst_resp),
        .inst_addr    (inst_addr),
        .inst_read    (inst_read),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    datapath_checks i_checks (
        .clk          (clk),
        .reset        (reset),
        .inst_read    (inst_read),
        .will_retire  (will_retire),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .exp_ready    (exp_ready),
        .exp_rd       (exp_head.rd),
        .exp_data     (exp_head.data),
        .failed       (check_failed)
    );

    task automatic abort_run(input string why);
        $display("%0t: %s", $time, why);
        $display("Something failed");
        $fatal(1);
    endtask

    function automatic void refresh_head();
        exp_ready = (exp_q.size() != 0);
        exp_head  = exp_ready ? exp_q[0] : '0;
    endfunction

    // few registers make dependencies frequent
    function automatic rv32i_reg_idx pick_reg();
        return rv32i_reg_idx'($unsigned($random(seed)) % 6);
    endfunction

    // RV32I result by funct3 where alt selects sub and sra
    function automatic rv32i_word reg_op(logic [2:0] f3, logic alt, rv32i_word a, rv32i_word b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? rv32i_word'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic make_inst(output rv32i_word inst);
        int           kind;
        logic [2:0]   f3;
        logic [6:0]   f7;
        rv32i_reg_idx rd;
        rv32i_reg_idx rs1;
        rv32i_reg_idx rs2;
        rv32i_word    rnd;
        kind = $unsigned($random(seed)) % 16;
        rnd  = $random(seed);
        rd   = pick_reg();
        rs1  = pick_reg();
        rs2  = pick_reg();
        f3   = rnd[14:12];
        f7   = (rnd[30] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00;
        if (kind < 6)  // shifts keep a clean upper immediate
            inst = {(f3[1:0] == 2'b01) ? {f7, rnd[24:20]} : rnd[31:20], rs1, f3, rd, 7'b0010011};
        else if (kind < 11)
            inst = {f7, rs2, rs1, f3, rd, 7'b0110011};
        else if (kind < 13)
            inst = {rnd[31:12], rd, 7'b0110111};
        else if (kind < 15)
            inst = {rnd[31:12], rd, 7'b0010111};
        else
            inst = {rnd[31:7], rnd[1:0], 5'b00011};  // load, store, madd or branch
    endtask

    task automatic model_inst(input rv32i_word pc, input rv32i_word inst, output logic live);
        rv32i_word    a;
        rv32i_word    imm;
        rv32i_word    res;
        rv32i_reg_idx rd;
        a    = model[inst[19:15]];
        imm  = {{20{inst[31]}}, inst[31:20]};
        rd   = inst[11:7];
        live = 1'b1;
        case (inst[6:0])
            7'b0110111: res = {inst[31:12], 12'h000};
            7'b0010111: res = pc + {inst[31:12], 12'h000};
            7'b0010011: res = reg_op(inst[14:12], inst[14:12] == 3'b101 && inst[30], a, imm);
            7'b0110011: res = reg_op(inst[14:12], inst[30], a, model[inst[24:20]]);
            default:    live = 1'b0;
        endcase
        live = live && (rd != '0);
        if (live) begin
            model[rd] = res;
            exp_q.push_back({rd, res});
            refresh_head();
        end
    endtask

    always @(posedge check_failed)
        abort_run("retire checker reported an error");

    // pops on the pre-edge retire_valid after the checker sampled the head
    always @(posedge clk) begin
        if (!reset && retire_valid && exp_q.size() != 0) begin
            exp_q.delete(0);
            refresh_head();
        end
    end

    initial begin
        int        delivered;
        int        cycles;
        rv32i_word req_addr;
        rv32i_word exp_addr;
        rv32i_word inst;
        logic      live;
        seed        = 32'hd326_c4bb;
        reset       = 1'b1;
        inst_resp   = 1'b0;
        inst_rdata  = '0;
        will_retire = 1'b0;
        delivered   = 0;
        cycles      = 0;
        exp_addr    = start_pc;
        foreach (model[i])
            model[i] = '0;
        refresh_head();
        repeat (10) @(negedge clk);
        reset = 1'b0;
        while (delivered < n_inst) begin
            if (cycles == max_cycles)
                abort_run("instruction delivery did not finish in time");
            cycles++;
            @(posedge clk);
            req_addr = inst_addr;  // the response driven next belongs to this address
            fetch_addr_ok: assert (req_addr == exp_addr)
                else begin
                    $display("FAIL %0t inst_addr got %h expected %h", $time,
                             req_addr, exp_addr);
                    abort_run("fetch address out of sequence");
                end
            @(negedge clk);
            if (($random(seed) & 3) == 0) begin
                inst_resp   = 1'b0;
                inst_rdata  = $random(seed);
                will_retire = 1'b0;
            end else begin
                make_inst(inst);
                model_inst(exp_addr, inst, live);
                inst_resp   = 1'b1;
                inst_rdata  = inst;
                will_retire = live;
                exp_addr    = exp_addr + 32'd4;
                delivered++;
            end
        end
        @(negedge clk);
        inst_resp   = 1'b0;
        will_retire = 1'b0;
        cycles      = 0;
        while (exp_ready && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        repeat (4) @(negedge clk);  // tail of bubbles through the latency check
        if (exp_ready)
            abort_run("expected results still pending after the drain timeout");
        else if (check_failed)
            abort_run("retire checker reported an error");
        else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule : datapath_tb

`default_nettype wire

/* tb/datapath_checks.sv */
`timescale 1ns/10ps
`default_nettype none

module datapath_checks (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      inst_read,
    input  logic                      will_retire,  // delivery of a writing instruction
    input  logic                      retire_valid,
    input  rv32i_types::rv32i_reg_idx retire_rd,
    input  rv32i_types::rv32i_word    retire_data,
    input  logic                      exp_ready,
    input  rv32i_types::rv32i_reg_idx exp_rd,
    input  rv32i_types::rv32i_word    exp_data,
    output logic                      failed
);
    import rv32i_types::*;

    logic [2:0] strobe_dly;  // delivery strobe lined up with WB

    initial failed = 1'b0;

    always_ff @(posedge clk) begin
        if (reset)
            strobe_dly <= '0;
        else
            strobe_dly <= {strobe_dly[1:0], will_retire};
    end

    fetch_always_on: assert property (@(posedge clk) disable iff (reset) inst_read)
        else begin
            $display("%0t: inst_read dropped low outside reset", $time);
            failed = 1'b1;
        end

    // three cycles from the response to WB, gaps and x0 writes included
    retire_latency: assert property (@(posedge clk) disable iff (reset)
        retire_valid == strobe_dly[2])
        else begin
            $display("FAIL %0t retire_valid got %b expected %b", $time,
                     $sampled(retire_valid), $sampled(strobe_dly[2]));
            failed = 1'b1;
        end

    retire_expected: assert property (@(posedge clk) disable iff (reset)
        retire_valid |-> exp_ready)
        else begin
            $display("%0t: retire to x%0d with no result pending", $time, $sampled(retire_rd));
            failed = 1'b1;
        end

    retire_rd_match: assert property (@(posedge clk) disable iff (reset)
        (retire_valid && exp_ready) |-> (retire_rd == exp_rd))
        else begin
            $display("FAIL %0t retire_rd got %0d expected %0d", $time,
                     $sampled(retire_rd), $sampled(exp_rd));
            failed = 1'b1;
        end

    retire_data_match: assert property (@(posedge clk) disable iff (reset)
        (retire_valid && exp_ready) |-> (retire_data == exp_data))
        else begin
            $display("FAIL %0t retire_data got %h expected %h", $time,
                     $sampled(retire_data), $sampled(exp_data));
            failed = 1'b1;
        end

endmodule : datapath_checks

`default_nettype wire

/* hdl/datapath.sv */
`timescale 1ns/10ps
`default_nettype none

module datapath #(
    parameter rv32i_types::rv32i_word reset_pc = 32'h0000_0000
) (
    input  logic                      clk,
    input  logic                      reset,
    input  rv32i_types::rv32i_word    inst_rdata,
    input  logic                      inst_resp,
    output rv32i_types::rv32i_word    inst_addr,
    output logic                      inst_read,
    output logic                      retire_valid,
    output rv32i_types::rv32i_reg_idx retire_rd,
    output rv32i_types::rv32i_word    retire_data
);
    import rv32i_types::*;
    import ctrl_types::*;

    typedef struct packed {
        logic      valid;
        rv32i_word pc;
        rv32i_word inst;
    } if_id_t;

    typedef struct packed {
        rv32i_control_word ctrl;
        rv32i_word         pc;
        rv32i_reg_idx      rs1;
        rv32i_reg_idx      rs2;
        rv32i_word         rs1_data;
        rv32i_word         rs2_data;
        rv32i_word         imm;
    } id_ex_t;

    typedef struct packed {
        rv32i_control_word ctrl;
        rv32i_word         pc;
        rv32i_word         imm;
        rv32i_word         alu_out;
        logic              lt;
    } ex_wb_t;

    rv32i_word         pc;  // address of the request in flight
    if_id_t            if_id;
    id_ex_t            id_ex;
    ex_wb_t            ex_wb;
    rv32i_inst_fields  id_fields;
    rv32i_control_word ctrl_word;
    rv32i_word         imm;
    rv32i_word         rs1_out;
    rv32i_word         rs2_out;
    rv32i_word         fwd_a;
    rv32i_word         fwd_b;
    rv32i_word         alu_b;
    rv32i_word         alu_out;
    logic              lt;
    logic              wb_write;
    rv32i_word         wb_value;

    // IF: a response moves on to the next word, a gap re-requests the same one
    assign inst_read = 1'b1;
    assign inst_addr = inst_resp ? pc + 32'd4 : pc;

    always_ff @(posedge clk) begin
        if (reset)
            pc <= reset_pc;
        else if (inst_resp)
            pc <= pc + 32'd4;
    end

    always_ff @(posedge clk) begin
        if_id.pc    <= pc;
        if_id.inst  <= inst_rdata;
        if_id.valid <= inst_resp && !reset;  // gap becomes a bubble
    end

    // ID
    assign id_fields = if_id.inst;

    control_unit i_control_unit (
        .inst      (if_id.inst),
        .ctrl_word (ctrl_word),
        .imm       (imm)
    );

    regfile i_regfile (
        .clk   (clk),
        .reset (reset),
        .load  (wb_write),
        .dest  (ex_wb.ctrl.dest),
        .in    (wb_value),
        .src_a (id_fields.rs1),
        .src_b (id_fields.rs2),
        .reg_a (rs1_out),
        .reg_b (rs2_out)
    );

    always_ff @(posedge clk) begin
        id_ex.ctrl       <= ctrl_word;
        id_ex.ctrl.valid <= ctrl_word.valid && if_id.valid && !reset;
        id_ex.pc         <= if_id.pc;
        id_ex.rs1        <= id_fields.rs1;
        id_ex.rs2        <= id_fields.rs2;
        id_ex.rs1_data   <= rs1_out;
        id_ex.rs2_data   <= rs2_out;
        id_ex.imm        <= imm;
    end

    // EX, WB result overrides a stale regfile read
    assign fwd_a = (wb_write && ex_wb.ctrl.dest == id_ex.rs1) ? wb_value : id_ex.rs1_data;
    assign fwd_b = (wb_write && ex_wb.ctrl.dest == id_ex.rs2) ? wb_value : id_ex.rs2_data;
    assign alu_b = id_ex.ctrl.alu_use_imm ? id_ex.imm : fwd_b;

    alu i_alu (
        .aluop (id_ex.ctrl.aluop),
        .a     (fwd_a),
        .b     (alu_b),
        .f     (alu_out)
    );

    cmp i_cmp (
        .cmpop (id_ex.ctrl.cmpop),
        .a     (fwd_a),
        .b     (alu_b),
        .lt    (lt)
    );

    always_ff @(posedge clk) begin
        ex_wb.ctrl       <= id_ex.ctrl;
        ex_wb.ctrl.valid <= id_ex.ctrl.valid && !reset;
        ex_wb.pc         <= id_ex.pc;
        ex_wb.imm        <= id_ex.imm;
        ex_wb.alu_out    <= alu_out;
        ex_wb.lt         <= lt;
    end

    // WB
    assign wb_write = ex_wb.ctrl.valid && ex_wb.ctrl.load_regfile;

    always_comb begin
        unique case (ex_wb.ctrl.wb_sel)
            wb_alu:    wb_value = ex_wb.alu_out;
            wb_cmp:    wb_value = {31'b0, ex_wb.lt};
            wb_imm:    wb_value = ex_wb.imm;  // lui
            wb_pc_imm: wb_value = ex_wb.pc + ex_wb.imm;
            default:   wb_value = ex_wb.alu_out;
        endcase
    end

    assign retire_valid = wb_write;
    assign retire_rd    = ex_wb.ctrl.dest;
    assign retire_data  = wb_value;

    retire_idle_after_reset: assert property (@(posedge clk) reset |=> !retire_valid)
        else $error("retire_valid high in the cycle after reset");

    // decode and WB gating together keep x0 off the retire port
    retire_rd_nonzero: assert property (@(posedge clk) disable iff (reset)
        retire_valid |-> (retire_rd != '0))
        else $error("retire to x0");

endmodule : datapath

`default_nettype wire

/* hdl/cmp.sv */
`timescale 1ns/10ps
`default_nettype none

module cmp (
    input  ctrl_types::cmp_ops     cmpop,
    input  rv32i_types::rv32i_word a,
    input  rv32i_types::rv32i_word b,
    output logic                   lt
);
    import ctrl_types::*;

    // slt/slti vs sltu/sltiu, b is already the imm for the I forms
    always_comb begin
        unique case (cmpop)
            cmp_lt:  lt = $signed(a) < $signed(b);
            cmp_ltu: lt = a < b;
            default: lt = 1'b0;
        endcase
    end

endmodule : cmp

`default_nettype wire

/* hdl/alu.sv */
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  ctrl_types::alu_ops     aluop,
    input  rv32i_types::rv32i_word a,
    input  rv32i_types::rv32i_word b,
    output rv32i_types::rv32i_word f
);
    import rv32i_types::*;
    import ctrl_types::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];  // rs2[4:0] or imm[4:0]

    always_comb begin
        unique case (aluop)
            alu_add: f = a + b;
            alu_sll: f = a << shamt;
            alu_sra: f = rv32i_word'($signed(a) >>> shamt);
            alu_sub: f = a - b;
            alu_xor: f = a ^ b;
            alu_srl: f = a >> shamt;
            alu_or:  f = a | b;
            alu_and: f = a & b;
            default: f = a + b;
        endcase
    end

    // operands carrying data need a defined operation from the ID/EX word
    aluop_known: assert final ($isunknown({a, b}) || !$isunknown(aluop))
        else $error("alu operation unknown with live operands");

endmodule : alu

`default_nettype wire

/* hdl/regfile.sv */
`timescale 1ns/10ps
`default_nettype none

module regfile (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      load,
    input  rv32i_types::rv32i_reg_idx dest,
    input  rv32i_types::rv32i_word    in,
    input  rv32i_types::rv32i_reg_idx src_a,
    input  rv32i_types::rv32i_reg_idx src_b,
    output rv32i_types::rv32i_word    reg_a,
    output rv32i_types::rv32i_word    reg_b
);
    import rv32i_types::*;

    rv32i_word regs [1:31];  // no storage for x0
    logic      wr_en;

    assign wr_en = load && (dest != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (wr_en) begin
            regs[dest] <= in;
        end
    end

    // same-cycle write shows up on the read side
    function automatic rv32i_word read_port(rv32i_reg_idx src);
        if (src == '0)
            return '0;
        if (wr_en && src == dest)
            return in;
        return regs[src];
    endfunction

    always_comb reg_a = read_port(src_a);
    always_comb reg_b = read_port(src_b);

endmodule : regfile

`default_nettype wire

/* hdl/control_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module control_unit (
    input  rv32i_types::rv32i_word        inst,
    output ctrl_types::rv32i_control_word ctrl_word,
    output rv32i_types::rv32i_word        imm
);
    import rv32i_types::*;
    import ctrl_types::*;

    rv32i_inst_fields fields;
    rv32i_word        i_imm;
    rv32i_word        u_imm;
    logic             is_reg;

    assign fields = inst;
    assign i_imm  = {{21{inst[31]}}, inst[30:20]};
    assign u_imm  = {inst[31:12], 12'h000};
    assign is_reg = (fields.opcode == op_reg);

    always_comb begin
        ctrl_word      = '0;  // bubble unless decoded below
        ctrl_word.dest = fields.rd;
        imm            = i_imm;
        unique case (fields.opcode)
            op_imm, op_reg: begin
                ctrl_word.valid        = 1'b1;
                ctrl_word.load_regfile = (fields.rd != '0);
                ctrl_word.alu_use_imm  = !is_reg;
                ctrl_word.cmpop        = cmp_ops'(fields.funct3[0]);
                unique case (fields.funct3)
                    3'b000: ctrl_word.aluop = (is_reg && fields.funct7[5]) ? alu_sub : alu_add;
                    3'b001: ctrl_word.aluop = alu_sll;
                    3'b010, 3'b011: ctrl_word.wb_sel = wb_cmp;  // slt(i), slt(i)u
                    3'b100: ctrl_word.aluop = alu_xor;
                    3'b101: ctrl_word.aluop = fields.funct7[5] ? alu_sra : alu_srl;
                    3'b110: ctrl_word.aluop = alu_or;
                    3'b111: ctrl_word.aluop = alu_and;
                endcase
            end
            op_lui: begin
                ctrl_word.valid        = 1'b1;
                ctrl_word.load_regfile = (fields.rd != '0);
                ctrl_word.wb_sel       = wb_imm;
                imm                    = u_imm;
            end
            op_auipc: begin
                ctrl_word.valid        = 1'b1;
                ctrl_word.load_regfile = (fields.rd != '0);
                ctrl_word.wb_sel       = wb_pc_imm;
                imm                    = u_imm;
            end
            default: ;  // illegal or dropped opcode
        endcase
    end

endmodule : control_unit

`default_nettype wire

/* hdl/ctrl_types.sv */
`default_nettype none

// control-level types, decoded in ID and carried down the pipe
package ctrl_types;

    // funct3 codes, slt/sltu slots hold sra and sub
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_ops;

    typedef enum logic {
        cmp_lt  = 1'b0,  // funct3[0] of slt
        cmp_ltu = 1'b1   // funct3[0] of sltu
    } cmp_ops;

    typedef enum logic [1:0] {
        wb_alu,
        wb_cmp,
        wb_imm,
        wb_pc_imm  // auipc
    } wb_sel_t;

    typedef struct packed {
        logic                     valid;
        rv32i_types::rv32i_reg_idx dest;
        logic                     load_regfile;
        alu_ops                   aluop;
        cmp_ops                   cmpop;
        logic                     alu_use_imm;
        wb_sel_t                  wb_sel;
    } rv32i_control_word;

endpackage : ctrl_types

`default_nettype wire

/* hdl/rv32i_types.sv */
`default_nettype none

// machine-level types shared by the core and its testbench
package rv32i_types;

    typedef logic [31:0] rv32i_word;     // data or address word
    typedef logic [4:0]  rv32i_reg_idx;  // x0..x31
    typedef logic [2:0]  rv32i_funct3;
    typedef logic [6:0]  rv32i_funct7;

    // only the groups this core executes, everything else decodes as a bubble
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode;

    // R-type field split, the other formats reuse rd/rs1/funct3 from it
    typedef struct packed {
        rv32i_funct7  funct7;
        rv32i_reg_idx rs2;
        rv32i_reg_idx rs1;
        rv32i_funct3  funct3;
        rv32i_reg_idx rd;
        rv32i_opcode  opcode;
    } rv32i_inst_fields;

endpackage : rv32i_types

`default_nettype wire
